// File: vlog.f
logic/sys_bus_pkg.sv
logic/sys_bus_if.sv
logic/axi_sys_bridge.sv
logic/sys_bus_decoder.sv
logic/scratch_regs.sv
logic/hk_regs.sv
logic/axi_sys_top.sv
testbench/axi_sys_checker.sv
testbench/tb_axi_sys.sv

// File: Bender.yml
package:
  name: axi_sys

sources:
  - logic/sys_bus_pkg.sv
  - logic/sys_bus_if.sv
  - logic/axi_sys_bridge.sv
  - logic/sys_bus_decoder.sv
  - logic/scratch_regs.sv
  - logic/hk_regs.sv
  - logic/axi_sys_top.sv
  - target: test
    files:
      - testbench/axi_sys_checker.sv
      - testbench/tb_axi_sys.sv

// File: testbench/tb_axi_sys.sv
//--------------------
// Testbench for the AXI register island
// Table rows run in order, one row in flight at a time
// Scratch and LED state carries over from row to row
// Responses are compared in axi_sys_checker
//--------------------
`timescale 1ns/1ps

module tb_axi_sys;
  import sys_bus_pkg::*;

  localparam int NUM_ROWS  = 19;
  localparam int RUN_LIMIT = NUM_ROWS * (ACK_TIMEOUT + 20);  // Cycles before giving up
  localparam logic [1:0] K_WR   = 2'd0;
  localparam logic [1:0] K_RD   = 2'd1;
  localparam logic [1:0] K_BOTH = 2'd2;  // Write and read offered together

  typedef struct packed {
    logic [1:0]          kind;
    logic [AXI_AW-1:0]   addr;
    logic [AXI_DW-1:0]   data;   // Write data, or expected read data
    logic [3:0]          len;
    logic [2:0]          size;
    logic [AXI_IW-1:0]   id;
    logic [3:0]          dly;    // Extra cycles of bready/rready hold-off
    logic [1:0]          resp;
    logic [HK_LED_W-1:0] led;    // led_o at end of row
  } row_t;

  logic                axi_clk;
  logic                axi_rstn;
  logic                awvalid;
  logic                awready;
  logic                wvalid;
  logic                wready;
  logic [AXI_IW-1:0]   bid;
  resp_t               bresp;
  logic                bvalid;
  logic                bready;
  logic                arvalid;
  logic                arready;
  logic [AXI_IW-1:0]   rid;
  logic [AXI_DW-1:0]   rdata;
  resp_t               rresp;
  logic                rlast;
  logic                rvalid;
  logic                rready;
  logic [HK_LED_W-1:0] led;
  row_t                rows [NUM_ROWS];
  row_t                cur;            // Row on the bus
  int                  row_idx;
  logic                row_done;       // Pulse after the last handshake of a row
  int unsigned         err_cnt;
  int unsigned         cycles = 0;

  initial begin
    axi_clk = 1'b0;
    forever #4 axi_clk = ~axi_clk;  // 8 ns period
  end

  //--------------------
  // Test table
  initial begin
    // kind, addr, data, len, size, id, ready delay, resp, led
    rows[0]  = {K_WR, 32'h00000000, 32'h11110000, 4'd0, 3'd2, 8'h10, 4'd0, OKAY, 8'h00};
    rows[1]  = {K_WR, 32'h00000014, 32'hA5A55A5A, 4'd0, 3'd2, 8'h11, 4'd0, OKAY, 8'h00};
    rows[2]  = {K_WR, 32'h0000003C, 32'hDEADBEEF, 4'd0, 3'd2, 8'h12, 4'd2, OKAY, 8'h00};
    rows[3]  = {K_RD, 32'h00000000, 32'h11110000, 4'd0, 3'd2, 8'h20, 4'd0, OKAY, 8'h00};
    rows[4]  = {K_RD, 32'h00000014, 32'hA5A55A5A, 4'd0, 3'd2, 8'h21, 4'd0, OKAY, 8'h00};
    rows[5]  = {K_RD, 32'h0000003C, 32'hDEADBEEF, 4'd0, 3'd2, 8'h22, 4'd1, OKAY, 8'h00};
    rows[6]  = {K_RD, 32'h00100000, HK_ID_VALUE,  4'd0, 3'd2, 8'h30, 4'd0, OKAY, 8'h00};
    rows[7]  = {K_WR, 32'h00100004, 32'h5A5A5A96, 4'd0, 3'd2, 8'h31, 4'd0, OKAY, 8'h96};
    rows[8]  = {K_RD, 32'h00100004, 32'h00000096, 4'd0, 3'd2, 8'h32, 4'd0, OKAY, 8'h96};
    // Unmapped region, ends in the bridge timeout
    rows[9]  = {K_WR, 32'h00200000, 32'h12345678, 4'd0, 3'd2, 8'h40, 4'd0, SLVERR, 8'h96};
    rows[10] = {K_RD, 32'h00200008, 32'h00000000, 4'd0, 3'd2, 8'h41, 4'd3, SLVERR, 8'h96};
    // Burst and size errors, word 5 must keep its value
    rows[11] = {K_WR, 32'h00000014, 32'hFFFFFFFF, 4'd3, 3'd2, 8'h50, 4'd0, SLVERR, 8'h96};
    rows[12] = {K_WR, 32'h00000014, 32'hEEEEEEEE, 4'd0, 3'd1, 8'h51, 4'd0, SLVERR, 8'h96};
    rows[13] = {K_RD, 32'h00000014, 32'h00000000, 4'd1, 3'd2, 8'h52, 4'd0, SLVERR, 8'h96};
    rows[14] = {K_RD, 32'h00000014, 32'hA5A55A5A, 4'd0, 3'd2, 8'h53, 4'd0, OKAY, 8'h96};
    rows[15] = {K_BOTH, 32'h00000020, 32'h0BADF00D, 4'd0, 3'd2, 8'h60, 4'd0, OKAY, 8'h96};
    // Long back-pressure
    rows[16] = {K_WR, 32'h00000024, 32'h77778888, 4'd0, 3'd2, 8'h70, 4'd6, OKAY, 8'h96};
    rows[17] = {K_RD, 32'h00000024, 32'h77778888, 4'd0, 3'd2, 8'h71, 4'd6, OKAY, 8'h96};
    rows[18] = {K_BOTH, 32'h0000003C, 32'h0F0F0F0F, 4'd0, 3'd2, 8'h72, 4'd4, OKAY, 8'h96};
  end

  //--------------------
  // Driver, all inputs change on the falling edge
  initial begin
    axi_rstn = 1'b0;
    cur      = '0;
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    row_idx  = 0;
    row_done = 1'b0;
    repeat (10) @(posedge axi_clk);
    @(negedge axi_clk) axi_rstn = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(negedge axi_clk);
      cur     = rows[i];
      row_idx = i;
      awvalid = (cur.kind != K_RD);
      wvalid  = (cur.kind != K_RD);
      arvalid = (cur.kind != K_WR);
      fork
        if (cur.kind != K_RD) begin
          do @(posedge axi_clk); while (!awready);  // Handshake at this edge
          @(negedge axi_clk) awvalid = 1'b0;
        end
        if (cur.kind != K_RD) begin
          do @(posedge axi_clk); while (!wready);
          @(negedge axi_clk) wvalid = 1'b0;
        end
        if (cur.kind != K_WR) begin
          do @(posedge axi_clk); while (!arready);  // Blocked while the write runs
          @(negedge axi_clk) arvalid = 1'b0;
        end
        if (cur.kind != K_RD) begin
          do @(posedge axi_clk); while (!bvalid);
          repeat (cur.dly) @(posedge axi_clk);      // Hold-off, bvalid must stay
          @(negedge axi_clk) bready = 1'b1;
          @(negedge axi_clk) bready = 1'b0;
        end
        if (cur.kind != K_WR) begin
          do @(posedge axi_clk); while (!rvalid);
          repeat (cur.dly) @(posedge axi_clk);
          @(negedge axi_clk) rready = 1'b1;
          @(negedge axi_clk) rready = 1'b0;
        end
      join
      row_done = 1'b1;
      @(negedge axi_clk) row_done = 1'b0;
    end
    @(negedge axi_clk);
    $display("Tests run: %0d, errors: %0d", NUM_ROWS, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Run limit
  always @(posedge axi_clk) begin
    cycles <= cycles + 1;
    if (cycles == RUN_LIMIT) begin
      $display("Run timed out after %0d cycles, a response never arrived", RUN_LIMIT);
      $display("Checks failed");
      $finish;
    end
  end

  axi_sys_top dut (
    .axi_clk_i     (axi_clk),
    .axi_rstn_i    (axi_rstn),
    .axi_awid_i    (cur.id),
    .axi_awaddr_i  (cur.addr),
    .axi_awlen_i   (cur.len),
    .axi_awsize_i  (cur.size),
    .axi_awvalid_i (awvalid),
    .axi_awready_o (awready),
    .axi_wdata_i   (cur.data),
    .axi_wvalid_i  (wvalid),
    .axi_wready_o  (wready),
    .axi_bid_o     (bid),
    .axi_bresp_o   (bresp),
    .axi_bvalid_o  (bvalid),
    .axi_bready_i  (bready),
    .axi_arid_i    (cur.id),
    .axi_araddr_i  (cur.addr),
    .axi_arlen_i   (cur.len),
    .axi_arsize_i  (cur.size),
    .axi_arvalid_i (arvalid),
    .axi_arready_o (arready),
    .axi_rid_o     (rid),
    .axi_rdata_o   (rdata),
    .axi_rresp_o   (rresp),
    .axi_rlast_o   (rlast),
    .axi_rvalid_o  (rvalid),
    .axi_rready_i  (rready),
    .led_o         (led)
  );

  axi_sys_checker u_checker (
    .axi_clk_i   (axi_clk),
    .axi_rstn_i  (axi_rstn),
    .bid_i       (bid),
    .bresp_i     (bresp),
    .bvalid_i    (bvalid),
    .bready_i    (bready),
    .rid_i       (rid),
    .rdata_i     (rdata),
    .rresp_i     (rresp),
    .rlast_i     (rlast),
    .rvalid_i    (rvalid),
    .rready_i    (rready),
    .led_i       (led),
    .exp_b_i     (cur.kind != K_RD),
    .exp_r_i     (cur.kind != K_WR),
    .exp_id_i    (cur.id),
    .exp_resp_i  (cur.resp),
    .exp_rdata_i (cur.data),
    .exp_led_i   (cur.led),
    .row_idx_i   (row_idx),
    .row_done_i  (row_done),
    .err_cnt_o   (err_cnt)
  );

endmodule

// File: testbench/axi_sys_checker.sv
//--------------------
// Response checker for the AXI register island
// Samples B and R handshakes at the rising edge
// Expected values hold for the whole row
//--------------------
`timescale 1ns/1ps

module axi_sys_checker (
  input  logic                             axi_clk_i,
  input  logic                             axi_rstn_i,
  input  logic [sys_bus_pkg::AXI_IW-1:0]   bid_i,
  input  logic [1:0]                       bresp_i,
  input  logic                             bvalid_i,
  input  logic                             bready_i,
  input  logic [sys_bus_pkg::AXI_IW-1:0]   rid_i,
  input  logic [sys_bus_pkg::AXI_DW-1:0]   rdata_i,
  input  logic [1:0]                       rresp_i,
  input  logic                             rlast_i,
  input  logic                             rvalid_i,
  input  logic                             rready_i,
  input  logic [sys_bus_pkg::HK_LED_W-1:0] led_i,
  input  logic                             exp_b_i,      // Row expects a B response
  input  logic                             exp_r_i,      // Row expects an R response
  input  logic [sys_bus_pkg::AXI_IW-1:0]   exp_id_i,
  input  logic [1:0]                       exp_resp_i,
  input  logic [sys_bus_pkg::AXI_DW-1:0]   exp_rdata_i,
  input  logic [sys_bus_pkg::HK_LED_W-1:0] exp_led_i,
  input  int                               row_idx_i,
  input  logic                             row_done_i,
  output int unsigned                      err_cnt_o
);
  import sys_bus_pkg::*;

  int unsigned       row_errs  = 0;
  int unsigned       err_total = 0;
  logic              b_seen    = 1'b0;  // B handshake in this row
  logic              r_seen    = 1'b0;
  logic              b_stall   = 1'b0;  // bvalid without bready at last edge
  logic              r_stall   = 1'b0;
  logic [1:0]        b_resp_q;
  logic [AXI_IW-1:0] b_id_q;
  logic [1:0]        r_resp_q;
  logic [AXI_IW-1:0] r_id_q;
  logic [AXI_DW-1:0] r_data_q;

  assign err_cnt_o = err_total;

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %0t ns %s expected 0x%0h got 0x%0h", $time, name, exp, act);
      row_errs++;
    end
  endtask

  task automatic report_event(input string what);
    $display("Test %0d at %0t ns: %s", row_idx_i, $time, what);
    row_errs++;
  endtask

  always @(posedge axi_clk_i) begin
    if (!axi_rstn_i) begin
      b_stall = 1'b0;
      r_stall = 1'b0;
    end else begin
      //--------------------
      // Stalled responses must not move
      if (b_stall) begin
        if (!bvalid_i) report_event("bvalid dropped before bready");
        compare_value("axi_bresp_o (stalled)", b_resp_q, bresp_i);
        compare_value("axi_bid_o (stalled)", b_id_q, bid_i);
      end
      if (r_stall) begin
        if (!rvalid_i) report_event("rvalid dropped before rready");
        compare_value("axi_rresp_o (stalled)", r_resp_q, rresp_i);
        compare_value("axi_rid_o (stalled)", r_id_q, rid_i);
        compare_value("axi_rdata_o (stalled)", r_data_q, rdata_i);
      end

      // Valid raised in a row that has no such transfer
      if (bvalid_i && !exp_b_i && !b_stall) report_event("bvalid raised without a write");
      if (rvalid_i && !exp_r_i && !r_stall) report_event("rvalid raised without a read");

      b_stall  = bvalid_i && !bready_i;
      b_resp_q = bresp_i;
      b_id_q   = bid_i;
      r_stall  = rvalid_i && !rready_i;
      r_resp_q = rresp_i;
      r_id_q   = rid_i;
      r_data_q = rdata_i;

      //--------------------
      // Handshakes
      if (bvalid_i && bready_i) begin
        compare_value("axi_bresp_o", exp_resp_i, bresp_i);
        compare_value("axi_bid_o", exp_id_i, bid_i);
        b_seen = 1'b1;
      end
      if (rvalid_i && rready_i) begin
        if (exp_b_i && !b_seen) report_event("read finished before the write");
        compare_value("axi_rresp_o", exp_resp_i, rresp_i);
        compare_value("axi_rid_o", exp_id_i, rid_i);
        compare_value("axi_rdata_o", exp_rdata_i, rdata_i);
        compare_value("axi_rlast_o", 32'd1, rlast_i);  // Single beat
        r_seen = 1'b1;
      end

      // End of row
      if (row_done_i) begin
        if (exp_b_i && !b_seen) report_event("write response missing");
        if (exp_r_i && !r_seen) report_event("read response missing");
        compare_value("led_o", exp_led_i, led_i);
        $display("Test %0d done, %0d errors", row_idx_i, row_errs);
        err_total += row_errs;
        row_errs = 0;
        b_seen   = 1'b0;
        r_seen   = 1'b0;
      end
    end
  end

endmodule

// File: logic/axi_sys_top.sv
//--------------------
// Register island top, AXI3 single-beat slave
// Plain AXI ports, LED word on led_o
//--------------------
`timescale 1ns/1ps

module axi_sys_top (
  input  logic                                axi_clk_i,
  input  logic                                axi_rstn_i,
  input  logic [sys_bus_pkg::AXI_IW-1:0]      axi_awid_i,
  input  logic [sys_bus_pkg::AXI_AW-1:0]      axi_awaddr_i,
  input  logic [sys_bus_pkg::AXI_LEN_W-1:0]   axi_awlen_i,
  input  logic [sys_bus_pkg::AXI_SIZE_W-1:0]  axi_awsize_i,
  input  logic                                axi_awvalid_i,
  output logic                                axi_awready_o,
  input  logic [sys_bus_pkg::AXI_DW-1:0]      axi_wdata_i,
  input  logic                                axi_wvalid_i,
  output logic                                axi_wready_o,
  output logic [sys_bus_pkg::AXI_IW-1:0]      axi_bid_o,
  output sys_bus_pkg::resp_t                  axi_bresp_o,
  output logic                                axi_bvalid_o,
  input  logic                                axi_bready_i,
  input  logic [sys_bus_pkg::AXI_IW-1:0]      axi_arid_i,
  input  logic [sys_bus_pkg::AXI_AW-1:0]      axi_araddr_i,
  input  logic [sys_bus_pkg::AXI_LEN_W-1:0]   axi_arlen_i,
  input  logic [sys_bus_pkg::AXI_SIZE_W-1:0]  axi_arsize_i,
  input  logic                                axi_arvalid_i,
  output logic                                axi_arready_o,
  output logic [sys_bus_pkg::AXI_IW-1:0]      axi_rid_o,
  output logic [sys_bus_pkg::AXI_DW-1:0]      axi_rdata_o,
  output sys_bus_pkg::resp_t                  axi_rresp_o,
  output logic                                axi_rlast_o,
  output logic                                axi_rvalid_o,
  input  logic                                axi_rready_i,
  output logic [sys_bus_pkg::HK_LED_W-1:0]    led_o
);

  sys_bus_if bus_bridge ();   // Bridge to decoder
  sys_bus_if bus_scratch ();  // Decoder to scratch bank
  sys_bus_if bus_hk ();       // Decoder to housekeeping

  axi_sys_bridge u_bridge (.*, .bus_o(bus_bridge));

  sys_bus_decoder u_decoder (
    .axi_clk_i  (axi_clk_i),
    .axi_rstn_i (axi_rstn_i),
    .bus_i      (bus_bridge),
    .scratch_o  (bus_scratch),
    .hk_o       (bus_hk)
  );

  scratch_regs u_scratch (
    .axi_clk_i  (axi_clk_i),
    .axi_rstn_i (axi_rstn_i),
    .bus_i      (bus_scratch)
  );

  hk_regs u_hk (
    .axi_clk_i  (axi_clk_i),
    .axi_rstn_i (axi_rstn_i),
    .bus_i      (bus_hk),
    .led_o      (led_o)
  );

endmodule

// File: logic/hk_regs.sv
//--------------------
// Housekeeping registers
// Word 0 is a read-only ID, word 1 holds the LEDs
// Ack HK_ACK_DLY cycles after a strobe, needs HK_ACK_DLY of 2 or more
//--------------------
`timescale 1ns/1ps

module hk_regs (
  input  logic                              axi_clk_i,
  input  logic                              axi_rstn_i,
  sys_bus_if.s                              bus_i,
  output logic [sys_bus_pkg::HK_LED_W-1:0]  led_o
);
  import sys_bus_pkg::*;

  logic [REGION_LSB-3:0] word;     // Word offset in region
  logic [HK_LED_W-1:0]   led_q;
  logic [AXI_DW-1:0]     rd_word;
  logic [AXI_DW-1:0]     rdata_q;  // Captured at strobe
  logic [HK_ACK_DLY-1:0] dly_q;    // Ack delay line

  assign word = bus_i.addr[REGION_LSB-1:2];

  always_comb begin
    if (word == '0) begin
      rd_word = HK_ID_VALUE;
    end else if (word == 1) begin
      rd_word = {{(AXI_DW-HK_LED_W){1'b0}}, led_q};
    end else begin
      rd_word = '0;  // Unused offsets
    end
  end

  always_ff @(posedge axi_clk_i) begin
    if (!axi_rstn_i) begin
      led_q <= '0;
      dly_q <= '0;
    end else begin
      if (bus_i.wen && (word == 1)) begin
        led_q <= bus_i.wdata[HK_LED_W-1:0];  // ID writes dropped
      end
      dly_q <= {dly_q[HK_ACK_DLY-2:0], bus_i.wen || bus_i.ren};
    end
  end

  always_ff @(posedge axi_clk_i) begin
    if (bus_i.ren) begin
      rdata_q <= rd_word;
    end
  end

  assign bus_i.rdata = rdata_q;
  assign bus_i.ack   = dly_q[HK_ACK_DLY-1];
  assign led_o       = led_q;

endmodule

// File: logic/scratch_regs.sv
//--------------------
// Scratch register bank, SCRATCH_WORDS words
// Word select from addr bits 5:2, upper offset bits ignored
// Ack one cycle after a strobe
//--------------------
`timescale 1ns/1ps

module scratch_regs (
  input  logic  axi_clk_i,
  input  logic  axi_rstn_i,
  sys_bus_if.s  bus_i
);
  import sys_bus_pkg::*;

  logic [AXI_DW-1:0]        mem [SCRATCH_WORDS];
  logic [SCRATCH_IDX_W-1:0] idx;
  logic [AXI_DW-1:0]        rdata_q;  // Read word, valid with ack
  logic                     ack_q;

  assign idx = bus_i.addr[SCRATCH_IDX_W+1:2];  // Word offset

  //--------------------
  // Storage, cleared on reset
  always_ff @(posedge axi_clk_i) begin
    if (!axi_rstn_i) begin
      for (int i = 0; i < SCRATCH_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (bus_i.wen) begin
      mem[idx] <= bus_i.wdata;  // Full word write
    end
  end

  // Read data register
  always_ff @(posedge axi_clk_i) begin
    if (bus_i.ren) begin
      rdata_q <= mem[idx];
    end
  end

  // One-cycle ack for either strobe
  always_ff @(posedge axi_clk_i) begin
    if (!axi_rstn_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_i.wen || bus_i.ren;
    end
  end

  assign bus_i.rdata = rdata_q;
  assign bus_i.ack   = ack_q;

endmodule

// File: logic/sys_bus_decoder.sv
//--------------------
// Address decoder for the system bus
// Purely combinational, region from addr bits 23:20
// Unmapped regions read 0 and never ack, the bridge times out
//--------------------
`timescale 1ns/1ps

module sys_bus_decoder (
  input  logic  axi_clk_i,
  input  logic  axi_rstn_i,
  sys_bus_if.s  bus_i,      // From bridge
  sys_bus_if.m  scratch_o,  // Scratch bank
  sys_bus_if.m  hk_o        // Housekeeping
);
  import sys_bus_pkg::*;

  logic [REGION_W-1:0] region;
  logic                sel_scr;
  logic                sel_hk;

  assign region  = bus_i.addr[REGION_MSB:REGION_LSB];
  assign sel_scr = (region == REGION_SCRATCH);
  assign sel_hk  = (region == REGION_HK);

  //--------------------
  // Downstream, selected region only
  assign scratch_o.addr  = sel_scr ? bus_i.addr  : '0;
  assign scratch_o.wdata = sel_scr ? bus_i.wdata : '0;
  assign scratch_o.wen   = sel_scr && bus_i.wen;
  assign scratch_o.ren   = sel_scr && bus_i.ren;

  assign hk_o.addr  = sel_hk ? bus_i.addr  : '0;
  assign hk_o.wdata = sel_hk ? bus_i.wdata : '0;
  assign hk_o.wen   = sel_hk && bus_i.wen;
  assign hk_o.ren   = sel_hk && bus_i.ren;

  //--------------------
  // Upstream mux
  always_comb begin
    if (sel_scr) begin
      bus_i.rdata = scratch_o.rdata;
      bus_i.ack   = scratch_o.ack;
    end else if (sel_hk) begin
      bus_i.rdata = hk_o.rdata;
      bus_i.ack   = hk_o.ack;
    end else begin
      bus_i.rdata = '0;    // Unmapped
      bus_i.ack   = 1'b0;  // Left to bridge timeout
    end
  end

  // An ack from a region only ever answers a strobe sent to it
  a_ack_scr_sel : assert property (@(posedge axi_clk_i) disable iff (!axi_rstn_i)
    scratch_o.ack |-> sel_scr);
  a_ack_hk_sel : assert property (@(posedge axi_clk_i) disable iff (!axi_rstn_i)
    hk_o.ack |-> sel_hk);

endmodule

// File: logic/axi_sys_bridge.sv
//--------------------
// AXI3 slave to system bus bridge, one transfer in flight
// Write wins over read when both arrive in the same cycle
// Burst or non 4-byte size gives SLVERR with no bus access
// No ack within ACK_TIMEOUT cycles gives SLVERR
// W beat of a failed write must arrive before bready, else it is left over
// Write strobes ignored, every write replaces the full word
//--------------------
`timescale 1ns/1ps

module axi_sys_bridge (
  input  logic                                axi_clk_i,
  input  logic                                axi_rstn_i,
  // Write address
  input  logic [sys_bus_pkg::AXI_IW-1:0]      axi_awid_i,
  input  logic [sys_bus_pkg::AXI_AW-1:0]      axi_awaddr_i,
  input  logic [sys_bus_pkg::AXI_LEN_W-1:0]   axi_awlen_i,
  input  logic [sys_bus_pkg::AXI_SIZE_W-1:0]  axi_awsize_i,
  input  logic                                axi_awvalid_i,
  output logic                                axi_awready_o,
  // Write data
  input  logic [sys_bus_pkg::AXI_DW-1:0]      axi_wdata_i,
  input  logic                                axi_wvalid_i,
  output logic                                axi_wready_o,
  // Write response
  output logic [sys_bus_pkg::AXI_IW-1:0]      axi_bid_o,
  output sys_bus_pkg::resp_t                  axi_bresp_o,
  output logic                                axi_bvalid_o,
  input  logic                                axi_bready_i,
  // Read address
  input  logic [sys_bus_pkg::AXI_IW-1:0]      axi_arid_i,
  input  logic [sys_bus_pkg::AXI_AW-1:0]      axi_araddr_i,
  input  logic [sys_bus_pkg::AXI_LEN_W-1:0]   axi_arlen_i,
  input  logic [sys_bus_pkg::AXI_SIZE_W-1:0]  axi_arsize_i,
  input  logic                                axi_arvalid_i,
  output logic                                axi_arready_o,
  // Read data
  output logic [sys_bus_pkg::AXI_IW-1:0]      axi_rid_o,
  output logic [sys_bus_pkg::AXI_DW-1:0]      axi_rdata_o,
  output sys_bus_pkg::resp_t                  axi_rresp_o,
  output logic                                axi_rlast_o,
  output logic                                axi_rvalid_o,
  input  logic                                axi_rready_i,
  // System bus
  sys_bus_if.m                                bus_o
);
  import sys_bus_pkg::*;

  logic                 rdy_q;    // Low in first cycle after reset
  logic                 wr_do;    // Write busy until B handshake
  logic                 rd_do;    // Read busy until R handshake
  logic                 wait_q;   // Waiting for ack, error or timeout
  logic                 wdat_q;   // W beat taken
  logic                 err_q;    // Latched len/size error
  logic [AXI_IW-1:0]    id_q;     // Shared by B and R
  logic [AXI_AW-1:0]    addr_q;
  logic [AXI_DW-1:0]    wdata_q;
  logic [ACK_CNT_W-1:0] ack_cnt;  // Timeout counter, 0 when idle
  logic                 aw_hs;
  logic                 ar_hs;
  logic                 w_hs;
  logic                 aw_err;
  logic                 ar_err;
  logic                 tmo;
  logic                 done;     // Ends the bus phase
  logic                 slverr;

  //--------------------
  // Handshakes and checks
  assign axi_awready_o = rdy_q && !wr_do && !rd_do;
  assign axi_arready_o = rdy_q && !wr_do && !rd_do && !axi_awvalid_i;  // Write wins
  assign axi_wready_o  = wr_do && !wdat_q;  // One beat per write

  assign aw_hs = axi_awvalid_i && axi_awready_o;
  assign ar_hs = axi_arvalid_i && axi_arready_o;
  assign w_hs  = axi_wvalid_i && axi_wready_o;

  assign aw_err = (axi_awlen_i != '0) || (axi_awsize_i != AXI_SIZE_4B);
  assign ar_err = (axi_arlen_i != '0) || (axi_arsize_i != AXI_SIZE_4B);

  assign tmo    = (ack_cnt == ACK_CNT_W'(ACK_TIMEOUT));
  assign done   = wait_q && (bus_o.ack || tmo || err_q);
  // Error or timeout, bus ack never comes with a latched error
  assign slverr = err_q || !bus_o.ack;

  //--------------------
  // Busy state and strobes
  always_ff @(posedge axi_clk_i) begin
    if (!axi_rstn_i) begin
      rdy_q     <= 1'b0;
      wr_do     <= 1'b0;
      rd_do     <= 1'b0;
      wait_q    <= 1'b0;
      wdat_q    <= 1'b0;
      err_q     <= 1'b0;
      bus_o.wen <= 1'b0;
      bus_o.ren <= 1'b0;
    end else begin
      rdy_q <= 1'b1;
      if (aw_hs) begin
        wr_do <= 1'b1;
      end else if (axi_bvalid_o && axi_bready_i) begin
        wr_do <= 1'b0;  // Idle in the B handshake cycle
      end
      if (ar_hs) begin
        rd_do <= 1'b1;
      end else if (axi_rvalid_o && axi_rready_i) begin
        rd_do <= 1'b0;
      end
      if (aw_hs || ar_hs) begin
        wait_q <= 1'b1;
      end else if (done) begin
        wait_q <= 1'b0;
      end
      if (aw_hs) begin
        wdat_q <= 1'b0;
      end else if (w_hs) begin
        wdat_q <= 1'b1;
      end
      if (aw_hs) begin
        err_q <= aw_err;
      end else if (ar_hs) begin
        err_q <= ar_err;
      end
      // No strobe after error or timeout
      bus_o.wen <= w_hs && wait_q && !err_q;
      bus_o.ren <= ar_hs && !ar_err;
    end
  end

  // Payload latches
  always_ff @(posedge axi_clk_i) begin
    if (aw_hs) begin
      id_q   <= axi_awid_i;
      addr_q <= axi_awaddr_i;
    end else if (ar_hs) begin
      id_q   <= axi_arid_i;
      addr_q <= axi_araddr_i;
    end
    if (w_hs) begin
      wdata_q <= axi_wdata_i;
    end
  end

  assign bus_o.addr  = addr_q;
  assign bus_o.wdata = wdata_q;

  //--------------------
  // Ack timeout
  always_ff @(posedge axi_clk_i) begin
    if (!axi_rstn_i) begin
      ack_cnt <= '0;
    end else if (aw_hs || ar_hs) begin
      ack_cnt <= ACK_CNT_W'(1);  // Counts from acceptance
    end else if (done) begin
      ack_cnt <= '0;
    end else if (ack_cnt != '0) begin
      ack_cnt <= ack_cnt + 1'b1;
    end
  end

  //--------------------
  // Responses, held under back-pressure
  always_ff @(posedge axi_clk_i) begin
    if (!axi_rstn_i) begin
      axi_bvalid_o <= 1'b0;
      axi_bresp_o  <= OKAY;
      axi_rvalid_o <= 1'b0;
      axi_rresp_o  <= OKAY;
    end else begin
      if (done && wr_do) begin
        axi_bvalid_o <= 1'b1;
        axi_bresp_o  <= slverr ? SLVERR : OKAY;
      end else if (axi_bready_i) begin
        axi_bvalid_o <= 1'b0;
      end
      if (done && rd_do) begin
        axi_rvalid_o <= 1'b1;
        axi_rresp_o  <= slverr ? SLVERR : OKAY;
      end else if (axi_rready_i) begin
        axi_rvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge axi_clk_i) begin
    if (done && rd_do) begin
      axi_rdata_o <= slverr ? '0 : bus_o.rdata;  // Zero on any SLVERR
    end
  end

  assign axi_bid_o   = id_q;  // Frozen while busy
  assign axi_rid_o   = id_q;
  assign axi_rlast_o = axi_rvalid_o;  // Single beat

  // Strobes are exclusive and never overlap a pending response
  a_strobe_excl : assert property (@(posedge axi_clk_i) disable iff (!axi_rstn_i)
    !(bus_o.wen && bus_o.ren));
  a_no_strobe_pend : assert property (@(posedge axi_clk_i) disable iff (!axi_rstn_i)
    (axi_bvalid_o || axi_rvalid_o) |-> !(bus_o.wen || bus_o.ren));

endmodule

// File: logic/sys_bus_if.sv
//--------------------
// Simple system bus, one transfer at a time
// wen and ren are single-cycle pulses, ack is a single-cycle pulse
// addr and wdata held until the transfer ends
//--------------------
`timescale 1ns/1ps

interface sys_bus_if;
  import sys_bus_pkg::*;

  logic [AXI_AW-1:0] addr;   // Byte address
  logic [AXI_DW-1:0] wdata;  // Write word
  logic              wen;    // Write strobe
  logic              ren;    // Read strobe
  logic [AXI_DW-1:0] rdata;  // Valid with ack
  logic              ack;    // Transfer done

  // Bus owner side
  modport m (output addr, wdata, wen, ren, input rdata, ack);

  // Register side
  modport s (input addr, wdata, wen, ren, output rdata, ack);

endinterface

// File: logic/sys_bus_pkg.sv
//--------------------
// Shared constants for the AXI register island
// Data path is fixed at 32 bits, single beat only
// Region select uses address bits 23:20, other bits are offsets
// Codes other than scratch and HK are unmapped
//--------------------
package sys_bus_pkg;

  // AXI side widths
  localparam int unsigned AXI_AW      = 32;       // Address width
  localparam int unsigned AXI_DW      = 32;       // Data width
  localparam int unsigned AXI_IW      = 8;        // ID width
  localparam int unsigned AXI_LEN_W   = 4;        // AXI3 burst length field
  localparam int unsigned AXI_SIZE_W  = 3;        // Burst size field
  localparam logic [AXI_SIZE_W-1:0] AXI_SIZE_4B = 3'b010;  // Only legal size

  // Bridge and slave timing
  localparam int unsigned ACK_TIMEOUT = 32;       // Cycles until own SLVERR
  localparam int unsigned ACK_CNT_W   = 6;        // Timeout counter width
  localparam int unsigned HK_ACK_DLY  = 4;        // HK strobe to ack

  // Address map
  localparam int unsigned REGION_MSB  = 23;
  localparam int unsigned REGION_LSB  = 20;
  localparam int unsigned REGION_W    = REGION_MSB - REGION_LSB + 1;
  localparam logic [REGION_W-1:0] REGION_SCRATCH = 4'd0;
  localparam logic [REGION_W-1:0] REGION_HK      = 4'd1;

  // Register blocks
  localparam int unsigned SCRATCH_WORDS = 16;
  localparam int unsigned SCRATCH_IDX_W = $clog2(SCRATCH_WORDS);  // Addr bits 5:2
  localparam logic [AXI_DW-1:0] HK_ID_VALUE = 32'hC0DE_0A51;     // Fixed ID word
  localparam int unsigned HK_LED_W      = 8;

  // AXI response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_t;

endpackage
